/* clk_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_enable_gen
   import vic20_chip_pkg::*;
(
   input  logic        clk25,
   input  logic        pwr_up_reset_n,
   input  speed_mode_e i_speed_mode,
   input  logic        i_halt,
   output logic        o_cpu_ce,
   output logic        o_via_ce,
   output logic        o_via4_ce
);

   logic [4:0] div_cnt;     // 0..24
   logic [3:0] cpu_mask;    // Low divider bits that must be zero for cpu tick
   logic [3:0] via4_mask;   // Same for via4 tick
   logic       cpu_hit;
   logic       via4_hit;

   // Mode decode, all ticks land in steps 0..15
   always_comb begin
      case (i_speed_mode)
         speed_1mhz: begin
            cpu_mask  = 4'b1111;   // Step 0
            via4_mask = 4'b0011;   // Steps 0,4,8,12
         end
         speed_2mhz: begin
            cpu_mask  = 4'b0111;   // Steps 0,8
            via4_mask = 4'b0001;   // Even steps
         end
         default: begin            // speed_4mhz
            cpu_mask  = 4'b0011;
            via4_mask = 4'b0000;   // Every step below 16
         end
      endcase
   end

   assign cpu_hit  = ~div_cnt[4] & ((div_cnt[3:0] & cpu_mask) == 4'd0);
   assign via4_hit = ~div_cnt[4] & ((div_cnt[3:0] & via4_mask) == 4'd0);

   // ==============================
   // Divider and registered enables
   // ==============================

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         div_cnt   <= 5'd0;
         o_cpu_ce  <= 1'b0;
         o_via_ce  <= 1'b0;
         o_via4_ce <= 1'b0;
      end else begin
         div_cnt   <= (div_cnt == div_last) ? 5'd0 : div_cnt + 5'd1;
         o_cpu_ce  <= cpu_hit & ~i_halt;    // Halt stops all pacing
         o_via_ce  <= cpu_hit & ~i_halt;    // VIA phase 2 follows cpu
         o_via4_ce <= via4_hit & ~i_halt;
      end
   end

endmodule

`default_nettype wire

/* flist.f */
vic20_bus_pkg.sv
vic20_chip_pkg.sv
clk_enable_gen.sv
vic_regs.sv
sound_gen.sv
sys_ram.sv
wb_decode.sv
vic20_sys.sv
vic20_properties.sv
tb_clock_gen.sv
vic20_tb.sv

/* sound_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module sound_gen
   import vic20_chip_pkg::*;
(
   input  logic       clk25,
   input  logic       pwr_up_reset_n,
   input  logic       i_via4_ce,
   input  logic [7:0] i_base,
   input  logic [7:0] i_alto,
   input  logic [7:0] i_soprano,
   input  logic [3:0] i_volume,
   output logic [5:0] o_audio
);

   logic [7:0] voice_byte [3];   // 0 base, 1 alto, 2 soprano
   logic [2:0] presc_last [3];   // Prescaler wrap value
   logic [2:0] presc_cnt  [3];
   logic [6:0] voice_cnt  [3];
   logic [2:0] voice_sq;         // Square outputs
   logic [2:0] voice_on;         // Square gated by enable bit
   logic [1:0] high_cnt;         // Voices currently high

   assign voice_byte[0] = i_base;
   assign voice_byte[1] = i_alto;
   assign voice_byte[2] = i_soprano;

   assign presc_last[0] = base_prescale - 3'd1;
   assign presc_last[1] = alto_prescale - 3'd1;
   assign presc_last[2] = soprano_prescale - 3'd1;

   // ==============================
   // Voice counters
   // ==============================

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         for (int v = 0; v < 3; v++) begin
            presc_cnt[v] <= 3'd0;
            voice_cnt[v] <= 7'd0;
         end
         voice_sq <= 3'b000;
      end else if (i_via4_ce) begin
         for (int v = 0; v < 3; v++) begin
            if (voice_byte[v][7]) begin            // Bit 7 runs the voice
               if (presc_cnt[v] == presc_last[v]) begin
                  presc_cnt[v] <= 3'd0;
                  if (voice_cnt[v] == voice_top) begin
                     voice_cnt[v] <= voice_byte[v][6:0];   // Reload period
                     voice_sq[v]  <= ~voice_sq[v];
                  end else begin
                     voice_cnt[v] <= voice_cnt[v] + 7'd1;
                  end
               end else begin
                  presc_cnt[v] <= presc_cnt[v] + 3'd1;
               end
            end
         end
      end
   end

   // ==============================
   // Mixer
   // ==============================

   assign voice_on = voice_sq & {i_soprano[7], i_alto[7], i_base[7]};
   assign high_cnt = {1'b0, voice_on[0]} + {1'b0, voice_on[1]} + {1'b0, voice_on[2]};

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n)
         o_audio <= 6'd0;
      else
         o_audio <= {4'd0, high_cnt} * {2'd0, i_volume};   // Max 3 x 15
   end

endmodule

`default_nettype wire

/* sys_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_ram
   import vic20_bus_pkg::*;
(
   input  logic              clk25,
   input  logic              i_we,    // Already qualified to RAM region
   input  logic [addr_w-1:0] i_adr,
   input  logic [data_w-1:0] i_dat,
   output logic [data_w-1:0] o_q
);

   logic [data_w-1:0] mem [2**addr_w];   // 64 KiB, ROM areas included

   // ROM image starts blank
   initial begin
      for (int i = 0; i < 2**addr_w; i++)
         mem[i] = '0;
   end

   // Single port, read-first
   always_ff @(posedge clk25) begin
      if (i_we)
         mem[i_adr] <= i_dat;
      o_q <= mem[i_adr];   // Old data when reading a written address
   end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 3
) (
   output logic o_clk25,
   output logic o_pwr_up_reset_n
);

   // Free running clock
   initial begin
      o_clk25 = 1'b0;
      forever #(period_ns / 2) o_clk25 = ~o_clk25;
   end

   // Reset low for the first edges, released off the edge like other inputs
   initial begin
      o_pwr_up_reset_n = 1'b0;
      repeat (reset_cycles) @(posedge o_clk25);
      #10 o_pwr_up_reset_n = 1'b1;
   end

endmodule

`default_nettype wire

/* vic20_bus_pkg.sv */
`default_nettype none

package vic20_bus_pkg;

   // ==============================
   // Bus widths
   // ==============================

   localparam int addr_w = 16;              // 64 KiB address space
   localparam int data_w = 8;               // Byte-wide data path

   // ==============================
   // Address map
   // ==============================

   // Upper 12 address bits of the video/sound chip page, 9000-900F
   localparam logic [11:0] chip_page = 12'h900;

   // Region of one bus request
   //   region_chip     : chip page, overrides everything else
   //   region_rom      : top nibble 8, C, D, E or F, writes dropped
   //   region_io_other : rest of the 9xxx block, reads zero
   //   region_ram      : everything else
   typedef enum logic [1:0] {
      region_ram,
      region_rom,
      region_chip,
      region_io_other
   } mem_region_e;

endpackage

`default_nettype wire

/* vic20_chip_pkg.sv */
`default_nettype none

package vic20_chip_pkg;

   // ==============================
   // Chip register indices
   // ==============================

   typedef enum logic [3:0] {
      reg_xorigin,   // 0
      reg_yorigin,   // 1
      reg_cols,      // 2, bit 7 is screen/colour a9
      reg_rows,      // 3, bit 0 is 8x16 mode
      reg_raster,    // 4, raster line, no raster engine here
      reg_mem_ptr,   // 5, screen and char base
      reg_6,
      reg_7,
      reg_8,
      reg_9,
      reg_base,      // 10
      reg_alto,      // 11
      reg_soprano,   // 12
      reg_noise,     // 13, stored only
      reg_volume,    // 14, aux colour in high nibble
      reg_colour     // 15
   } chip_reg_e;

   // Processor pacing
   typedef enum logic [1:0] {speed_1mhz, speed_2mhz, speed_4mhz} speed_mode_e;

   // ==============================
   // Reset values
   // ==============================

   localparam logic [15:0] rst_screen_addr = 16'h1e00;
   localparam logic [15:0] rst_char_addr   = 16'h8000;
   localparam logic [15:0] rst_colour_addr = 16'h9400;
   localparam logic [6:0]  rst_xorigin     = 7'd12;
   localparam logic [7:0]  rst_yorigin     = 8'd38;
   localparam logic [6:0]  rst_cols        = 7'd22;
   localparam logic [6:0]  rst_rows        = 7'd23;

   // Divider and voice constants
   localparam logic [4:0] div_last         = 5'd24;   // 25 steps per period
   localparam logic [6:0] voice_top        = 7'd127;  // Voice counter limit
   localparam logic [2:0] base_prescale    = 3'd4;    // via4 ticks per step
   localparam logic [2:0] alto_prescale    = 3'd2;
   localparam logic [2:0] soprano_prescale = 3'd1;

endpackage

`default_nettype wire

/* vic20_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module vic20_properties (
   input logic clk25,
   input logic pwr_up_reset_n,
   input logic i_wb_cyc,
   input logic i_wb_stb,
   input logic i_wb_ack
);

   // ==============================
   // Wishbone slave handshake
   // ==============================

   // Ack is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      i_wb_ack |=> !i_wb_ack)
      else $error("Ack stayed high for two cycles");

   // No ack without a request on the cycle before
   ack_after_request: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
      else $error("Ack without cyc and stb on the previous cycle");

   ack_reset_low: assert property (@(posedge clk25)
      !pwr_up_reset_n |=> !i_wb_ack)   // Checked through reset too
      else $error("Ack high after a reset cycle");

endmodule

bind wb_decode vic20_properties u_props (
   .clk25          (clk25),
   .pwr_up_reset_n (pwr_up_reset_n),
   .i_wb_cyc       (i_wb_cyc),
   .i_wb_stb       (i_wb_stb),
   .i_wb_ack       (o_wb_ack)
);

`default_nettype wire

/* vic20_sys.sv */
`timescale 1ns/1ps
`default_nettype none

module vic20_sys
   import vic20_bus_pkg::*, vic20_chip_pkg::*;
(
   input  logic              clk25,
   input  logic              pwr_up_reset_n,
   input  logic              i_wb_cyc,
   input  logic              i_wb_stb,
   input  logic              i_wb_we,
   input  logic [addr_w-1:0] i_wb_adr,
   input  logic [data_w-1:0] i_wb_dat,
   input  speed_mode_e       i_speed_mode,
   input  logic              i_halt,
   output logic              o_wb_ack,
   output logic [data_w-1:0] o_wb_dat,
   output logic              o_cpu_ce,
   output logic              o_via_ce,
   output logic              o_via4_ce,
   output logic [5:0]        o_audio,
   output logic [15:0]       o_screen_addr,
   output logic [15:0]       o_char_addr,
   output logic [15:0]       o_colour_addr,
   output logic [6:0]        o_xorigin,
   output logic [7:0]        o_yorigin,
   output logic [6:0]        o_cols,
   output logic [6:0]        o_rows,
   output logic              o_chars8x16,
   output logic [2:0]        o_border,
   output logic [3:0]        o_back,
   output logic [3:0]        o_aux,
   output logic              o_inverted
);

   // Decode to register bank
   logic              reg_we;
   chip_reg_e         reg_idx;
   logic [data_w-1:0] reg_dat;
   logic [data_w-1:0] reg_q;
   // Decode to memory
   logic              ram_we;
   logic [addr_w-1:0] ram_adr;
   logic [data_w-1:0] ram_dat;
   logic [data_w-1:0] ram_q;
   // Voice bytes and volume
   logic [7:0]        base;
   logic [7:0]        alto;
   logic [7:0]        soprano;
   logic [3:0]        volume;

   wb_decode u_wb_decode (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_wb_cyc       (i_wb_cyc),
      .i_wb_stb       (i_wb_stb),
      .i_wb_we        (i_wb_we),
      .i_wb_adr       (i_wb_adr),
      .i_wb_dat       (i_wb_dat),
      .o_wb_ack       (o_wb_ack),
      .o_wb_dat       (o_wb_dat),
      .i_reg_q        (reg_q),
      .o_reg_we       (reg_we),
      .o_reg_idx      (reg_idx),
      .o_reg_dat      (reg_dat),
      .i_ram_q        (ram_q),
      .o_ram_we       (ram_we),
      .o_ram_adr      (ram_adr),
      .o_ram_dat      (ram_dat)
   );

   vic_regs u_vic_regs (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_reg_we       (reg_we),
      .i_reg_idx      (reg_idx),
      .i_reg_dat      (reg_dat),
      .o_reg_q        (reg_q),
      .o_base         (base),
      .o_alto         (alto),
      .o_soprano      (soprano),
      .o_volume       (volume),
      .o_screen_addr  (o_screen_addr),
      .o_char_addr    (o_char_addr),
      .o_colour_addr  (o_colour_addr),
      .o_xorigin      (o_xorigin),
      .o_yorigin      (o_yorigin),
      .o_cols         (o_cols),
      .o_rows         (o_rows),
      .o_chars8x16    (o_chars8x16),
      .o_border       (o_border),
      .o_back         (o_back),
      .o_aux          (o_aux),
      .o_inverted     (o_inverted)
   );

   sound_gen u_sound_gen (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_via4_ce      (o_via4_ce),   // Voices step on the VIA timer tick
      .i_base         (base),
      .i_alto         (alto),
      .i_soprano      (soprano),
      .i_volume       (volume),
      .o_audio        (o_audio)
   );

   sys_ram u_sys_ram (
      .clk25 (clk25),
      .i_we  (ram_we),
      .i_adr (ram_adr),
      .i_dat (ram_dat),
      .o_q   (ram_q)
   );

   clk_enable_gen u_clk_enable_gen (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_speed_mode   (i_speed_mode),
      .i_halt         (i_halt),
      .o_cpu_ce       (o_cpu_ce),
      .o_via_ce       (o_via_ce),
      .o_via4_ce      (o_via4_ce)
   );

endmodule

`default_nettype wire

/* vic20_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vic20_tb
   import vic20_bus_pkg::*, vic20_chip_pkg::*;
();

   // ==============================
   // Run length and timing
   // ==============================

   localparam int clk_period_ns  = 100;
   localparam int drive_delay_ns = 10;    // Inputs change after the edge
   localparam int ack_timeout    = 8;
   localparam int count_window   = 250;   // Ten divider periods
   localparam int voice_window   = 128 * 4 * 25;
   localparam int quiet_cycles   = 200;
   localparam int bus_accesses   = 5 + 3 * 32 + 48 + 12;
   localparam int test_cycles    = bus_accesses * 4 + 5 * (count_window + 4)
                                   + 3 * voice_window + quiet_cycles;
   localparam int watchdog_cycles = 2 * test_cycles + 100;

   logic              clk25;
   logic              pwr_up_reset_n;
   logic              i_wb_cyc;
   logic              i_wb_stb;
   logic              i_wb_we;
   logic [addr_w-1:0] i_wb_adr;
   logic [data_w-1:0] i_wb_dat;
   speed_mode_e       i_speed_mode;
   logic              i_halt;
   logic              o_wb_ack;
   logic [data_w-1:0] o_wb_dat;
   logic              o_cpu_ce;
   logic              o_via_ce;
   logic              o_via4_ce;
   logic [5:0]        o_audio;
   logic [15:0]       o_screen_addr;
   logic [15:0]       o_char_addr;
   logic [15:0]       o_colour_addr;
   logic [6:0]        o_xorigin;
   logic [7:0]        o_yorigin;
   logic [6:0]        o_cols;
   logic [6:0]        o_rows;
   logic              o_chars8x16;
   logic [2:0]        o_border;
   logic [3:0]        o_back;
   logic [3:0]        o_aux;
   logic              o_inverted;

   logic [7:0] reg_model [16];               // Expected readback per index
   logic [7:0] ram_model [logic [15:0]];     // Written RAM bytes
   int         mismatch_cnt = 0;
   int         fail_cnt     = 0;

   tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(3)) u_clock (
      .o_clk25          (clk25),
      .o_pwr_up_reset_n (pwr_up_reset_n)
   );

   vic20_sys dut0 (.*);

   // ==============================
   // Compare tasks
   // ==============================

   task automatic check_byte(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                             input string what);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                             input string what);
      if (got !== exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         mismatch_cnt++;
         $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // ==============================
   // Bus and pacing helpers
   // ==============================

   // One Wishbone classic transfer, stb held one cycle past ack
   task automatic bus_access(input logic we, input logic [addr_w-1:0] adr,
                             input logic [data_w-1:0] dat, output logic [data_w-1:0] q);
      int waited;
      @(posedge clk25);
      #drive_delay_ns;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = adr;
      i_wb_dat = dat;
      @(negedge clk25);
      if (o_wb_ack) begin
         fail_cnt++;
         $display("Ack was high before the request at %h was seen", adr);
      end
      waited = 0;
      do begin
         @(negedge clk25);
         waited++;
      end while (!o_wb_ack && waited < ack_timeout);
      if (!o_wb_ack) begin
         fail_cnt++;
         $display("No ack for address %h within %0d cycles", adr, ack_timeout);
      end else if (waited != 1) begin
         fail_cnt++;
         $display("Ack for address %h came after %0d cycles, not 1", adr, waited);
      end
      q = o_wb_dat;                       // Valid while ack high
      @(posedge clk25);
      #drive_delay_ns;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      @(negedge clk25);
      if (o_wb_ack) begin
         fail_cnt++;
         $display("Ack for address %h lasted more than one cycle", adr);
      end
   endtask

   task automatic wb_write(input logic [addr_w-1:0] adr, input logic [data_w-1:0] dat);
      logic [data_w-1:0] unused_q;
      bus_access(1'b1, adr, dat, unused_q);
   endtask

   task automatic wb_read(input logic [addr_w-1:0] adr, output logic [data_w-1:0] q);
      bus_access(1'b0, adr, 8'h00, q);
   endtask

   function automatic logic [addr_w-1:0] chip_adr(input int idx);
      return {chip_page, 4'(idx)};
   endfunction

   // Raster line and the unused slots
   function automatic logic reads_zero(input int idx);
      return idx == 4 || (idx >= 6 && idx <= 9);
   endfunction

   task automatic set_pace(input speed_mode_e mode, input logic halt);
      @(posedge clk25);
      #drive_delay_ns;
      i_speed_mode = mode;
      i_halt       = halt;
      repeat (2) @(posedge clk25);        // Enables are one cycle late
   endtask

   task automatic count_enables(output int n_cpu, output int n_via, output int n_via4);
      n_cpu  = 0;
      n_via  = 0;
      n_via4 = 0;
      repeat (count_window) begin
         @(negedge clk25);
         if (o_cpu_ce)  n_cpu++;
         if (o_via_ce)  n_via++;
         if (o_via4_ce) n_via4++;
      end
   endtask

   // Video outputs against the register model
   task automatic check_video();
      logic [7:0] mp;
      logic [7:0] cl;
      mp = reg_model[5];
      cl = reg_model[2];
      check_addr(o_screen_addr, {~mp[7], 2'b00, mp[6:4], cl[7], 9'h000}, "screen base");
      check_addr(o_char_addr, {~mp[3], 2'b00, mp[2:0], 10'h000}, "char base");
      check_addr(o_colour_addr, {6'b100101, cl[7], 9'h000}, "colour base");
      check_byte({1'b0, o_xorigin}, {1'b0, reg_model[0][6:0]}, "xorigin");
      check_byte(o_yorigin, reg_model[1], "yorigin");
      check_byte({1'b0, o_cols}, {1'b0, cl[6:0]}, "cols");
      check_byte({1'b0, o_rows}, {1'b0, reg_model[3][6:0]}, "rows");
      check_byte({7'd0, o_chars8x16}, {7'd0, reg_model[3][0]}, "8x16 mode");
      check_byte({5'd0, o_border}, {5'd0, reg_model[15][2:0]}, "border");
      check_byte({7'd0, o_inverted}, {7'd0, reg_model[15][3]}, "inverted");
      check_byte({4'd0, o_back}, {4'd0, reg_model[15][7:4]}, "background");
      check_byte({4'd0, o_aux}, {4'd0, reg_model[14][7:4]}, "aux colour");
   endtask

   // ==============================
   // Directed tests
   // ==============================

   task automatic test_reset_values();
      logic [7:0] q;
      #1;
      check_byte({7'd0, o_wb_ack}, 8'h00, "ack after reset");
      check_byte({5'd0, o_cpu_ce, o_via_ce, o_via4_ce}, 8'h00, "enables after reset");
      check_byte({2'd0, o_audio}, 8'h00, "audio after reset");
      wb_read(chip_adr(0), q);
      check_byte(q, 8'd12, "reset xorigin reg");
      wb_read(chip_adr(1), q);
      check_byte(q, 8'd38, "reset yorigin reg");
      wb_read(chip_adr(2), q);
      check_byte(q, 8'h96, "reset cols reg");      // 22 plus screen a9 of 1E00
      wb_read(chip_adr(3), q);
      check_byte(q, 8'h17, "reset rows reg");
      wb_read(chip_adr(5), q);
      check_byte(q, 8'hf0, "reset mem_ptr reg");   // 1E00 and 8000 encoded
      check_addr(o_screen_addr, 16'h1e00, "reset screen base");
      check_addr(o_char_addr, 16'h8000, "reset char base");
      check_addr(o_colour_addr, 16'h9400, "reset colour base");
      check_byte({1'b0, o_xorigin}, 8'd12, "reset xorigin");
      check_byte(o_yorigin, 8'd38, "reset yorigin");
      check_byte({1'b0, o_cols}, 8'd22, "reset cols");
      check_byte({1'b0, o_rows}, 8'd23, "reset rows");
   endtask

   task automatic test_chip_regs();
      logic [7:0] dat;
      logic [7:0] q;
      for (int round = 0; round < 3; round++) begin
         for (int i = 0; i < 16; i++) begin
            dat = 8'($urandom());
            wb_write(chip_adr(i), dat);
            reg_model[i] = reads_zero(i) ? 8'h00 : dat;
         end
         for (int i = 0; i < 16; i++) begin
            wb_read(chip_adr(i), q);
            check_byte(q, reg_model[i], $sformatf("chip register %0d", i));
         end
         check_video();
      end
   endtask

   task automatic test_memory();
      logic [15:0] adr;
      logic [7:0]  dat;
      logic [7:0]  q;
      logic [15:0] ram_adrs [$];
      logic [15:0] rom_adrs [$];
      logic [3:0]  rom_nib [5] = '{4'h8, 4'hc, 4'hd, 4'he, 4'hf};
      for (int k = 0; k < 16; k++) begin
         adr = {1'b0, 15'($urandom())};   // Lower half is all RAM
         dat = 8'($urandom());
         wb_write(adr, dat);
         ram_model[adr] = dat;
         ram_adrs.push_back(adr);
      end
      foreach (ram_adrs[k]) begin
         wb_read(ram_adrs[k], q);
         check_byte(q, ram_model[ram_adrs[k]], $sformatf("RAM at %h", ram_adrs[k]));
      end
      for (int k = 0; k < 8; k++) begin
         adr = {rom_nib[$urandom_range(4)], 12'($urandom())};
         wb_write(adr, 8'($urandom_range(255, 1)));   // Never the blank value
         rom_adrs.push_back(adr);
      end
      foreach (rom_adrs[k]) begin
         wb_read(rom_adrs[k], q);
         check_byte(q, 8'h00, $sformatf("ROM at %h after write", rom_adrs[k]));
      end
   endtask

   task automatic test_clock_enables();
      speed_mode_e modes [3] = '{speed_1mhz, speed_2mhz, speed_4mhz};
      int          cpu_per25 [3] = '{1, 2, 4};   // via4 runs four times faster
      int          n_cpu;
      int          n_via;
      int          n_via4;
      for (int m = 0; m < 3; m++) begin
         set_pace(modes[m], 1'b0);
         count_enables(n_cpu, n_via, n_via4);
         check_count(n_cpu, 10 * cpu_per25[m], {"cpu_ce count in ", modes[m].name()});
         check_count(n_via, 10 * cpu_per25[m], {"via_ce count in ", modes[m].name()});
         check_count(n_via4, 40 * cpu_per25[m], {"via4_ce count in ", modes[m].name()});
      end
      set_pace(speed_4mhz, 1'b1);
      count_enables(n_cpu, n_via, n_via4);
      check_count(n_cpu + n_via + n_via4, 0, "enable count with halt");
      set_pace(speed_1mhz, 1'b0);
   endtask

   task automatic test_sound();
      logic [3:0] vol;
      logic [7:0] voice [3];
      logic [5:0] first;
      logic       changed;
      logic       bad;
      set_pace(speed_1mhz, 1'b0);
      vol = 4'(1 + $urandom_range(14));
      for (int v = 0; v < 3; v++) begin
         voice[v] = {1'b0, 7'($urandom())};
         wb_write(chip_adr(10 + v), voice[v]);
      end
      wb_write(chip_adr(14), {4'($urandom()), vol});
      repeat (quiet_cycles) begin
         @(negedge clk25);
         check_byte({2'd0, o_audio}, 8'h00, "audio with voices off");
      end
      // One voice at a time, square level is 0 or the volume
      for (int v = 0; v < 3; v++) begin
         wb_write(chip_adr(10 + v), voice[v] | 8'h80);
         first   = o_audio;
         changed = 1'b0;
         bad     = 1'b0;
         for (int n = 0; n < voice_window && !bad; n++) begin
            @(negedge clk25);
            if (o_audio != 6'd0 && o_audio != {2'd0, vol}) begin
               check_byte({2'd0, o_audio}, {4'd0, vol}, $sformatf("audio of voice %0d", v));
               bad = 1'b1;
            end
            if (o_audio != first)
               changed = 1'b1;
         end
         if (!changed && !bad) begin
            fail_cnt++;
            $display("Audio of voice %0d did not change within %0d cycles", v, voice_window);
         end
         wb_write(chip_adr(10 + v), voice[v]);   // Voice off again
      end
   endtask

   // ==============================
   // Main sequence and watchdog
   // ==============================

   initial begin
      i_wb_cyc     = 1'b0;
      i_wb_stb     = 1'b0;
      i_wb_we      = 1'b0;
      i_wb_adr     = '0;
      i_wb_dat     = '0;
      i_speed_mode = speed_1mhz;
      i_halt       = 1'b0;
      void'($urandom(32'hd8ff_976f));
      @(posedge pwr_up_reset_n);
      test_reset_values();
      test_chip_regs();
      test_memory();
      test_clock_enables();
      test_sound();
      $display("Checks done: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      if (mismatch_cnt + fail_cnt == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      #(watchdog_cycles * clk_period_ns);
      $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* vic_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_regs
   import vic20_bus_pkg::*, vic20_chip_pkg::*;
(
   input  logic              clk25,
   input  logic              pwr_up_reset_n,
   input  logic              i_reg_we,
   input  chip_reg_e         i_reg_idx,
   input  logic [data_w-1:0] i_reg_dat,
   output logic [data_w-1:0] o_reg_q,
   // Sound
   output logic [7:0]        o_base,
   output logic [7:0]        o_alto,
   output logic [7:0]        o_soprano,
   output logic [3:0]        o_volume,
   // Video configuration
   output logic [15:0]       o_screen_addr,
   output logic [15:0]       o_char_addr,
   output logic [15:0]       o_colour_addr,
   output logic [6:0]        o_xorigin,
   output logic [7:0]        o_yorigin,
   output logic [6:0]        o_cols,
   output logic [6:0]        o_rows,
   output logic              o_chars8x16,
   output logic [2:0]        o_border,
   output logic [3:0]        o_back,
   output logic [3:0]        o_aux,
   output logic              o_inverted
);

   logic [data_w-1:0] regs [16];   // Last written byte per index
   logic              colour_a9;   // Colour RAM a9, own reset value

   // Raster line and unused indices hold nothing
   function automatic logic writable(chip_reg_e idx);
      return !(idx inside {reg_raster, reg_6, reg_7, reg_8, reg_9});
   endfunction

   // Bytes that reproduce the reset configuration
   function automatic logic [7:0] reset_byte(chip_reg_e idx);
      case (idx)
         reg_xorigin: return {1'b0, rst_xorigin};
         reg_yorigin: return rst_yorigin;
         reg_cols:    return {rst_screen_addr[9], rst_cols};
         reg_rows:    return {1'b0, rst_rows};
         reg_mem_ptr: return {~rst_screen_addr[15], rst_screen_addr[12:10],
                              ~rst_char_addr[15], rst_char_addr[12:10]};
         default:     return 8'h00;   // Voices off, volume 0
      endcase
   endfunction

   // ==============================
   // Register writes
   // ==============================

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         for (int i = 0; i < 16; i++)
            regs[i] <= reset_byte(chip_reg_e'(i));
         colour_a9 <= rst_colour_addr[9];
      end else if (i_reg_we) begin
         if (writable(i_reg_idx))
            regs[i_reg_idx] <= i_reg_dat;
         if (i_reg_idx == reg_cols)
            colour_a9 <= i_reg_dat[7];      // Shares bit 7 with screen a9
      end
   end

   assign o_reg_q = writable(i_reg_idx) ? regs[i_reg_idx] : '0;   // Reg 4 reads 0

   // ==============================
   // Field mapping
   // ==============================

   // Base addresses, inverted top bit as on the real chip
   assign o_screen_addr = {~regs[reg_mem_ptr][7], rst_screen_addr[14:13],
                           regs[reg_mem_ptr][6:4], regs[reg_cols][7],
                           rst_screen_addr[8:0]};
   assign o_char_addr   = {~regs[reg_mem_ptr][3], rst_char_addr[14:13],
                           regs[reg_mem_ptr][2:0], rst_char_addr[9:0]};
   assign o_colour_addr = {rst_colour_addr[15:10], colour_a9, rst_colour_addr[8:0]};

   assign o_xorigin   = regs[reg_xorigin][6:0];
   assign o_yorigin   = regs[reg_yorigin];
   assign o_cols      = regs[reg_cols][6:0];
   assign o_rows      = regs[reg_rows][6:0];
   assign o_chars8x16 = regs[reg_rows][0];       // Overlaps rows lsb
   assign o_border    = regs[reg_colour][2:0];
   assign o_inverted  = regs[reg_colour][3];
   assign o_back      = regs[reg_colour][7:4];
   assign o_aux       = regs[reg_volume][7:4];

   // Sound side
   assign o_base    = regs[reg_base];
   assign o_alto    = regs[reg_alto];
   assign o_soprano = regs[reg_soprano];
   assign o_volume  = regs[reg_volume][3:0];

endmodule

`default_nettype wire

/* wb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_decode
   import vic20_bus_pkg::*, vic20_chip_pkg::*;
(
   input  logic              clk25,
   input  logic              pwr_up_reset_n,
   // Wishbone classic slave
   input  logic              i_wb_cyc,
   input  logic              i_wb_stb,
   input  logic              i_wb_we,
   input  logic [addr_w-1:0] i_wb_adr,
   input  logic [data_w-1:0] i_wb_dat,
   output logic              o_wb_ack,
   output logic [data_w-1:0] o_wb_dat,
   // Chip register bank
   input  logic [data_w-1:0] i_reg_q,
   output logic              o_reg_we,
   output chip_reg_e         o_reg_idx,
   output logic [data_w-1:0] o_reg_dat,
   // System memory
   input  logic [data_w-1:0] i_ram_q,
   output logic              o_ram_we,
   output logic [addr_w-1:0] o_ram_adr,
   output logic [data_w-1:0] o_ram_dat
);

   mem_region_e       region;     // Region of the address on the bus
   mem_region_e       region_q;   // Region of the acked transfer
   logic              seen;       // New transfer this cycle
   logic [data_w-1:0] reg_hold;   // Register readback, valid with ack

   // ==============================
   // Address decode
   // ==============================

   always_comb begin
      if (i_wb_adr[15:4] == chip_page) begin
         region = region_chip;
      end else begin
         case (i_wb_adr[15:12])
            4'h8, 4'hc, 4'hd, 4'he, 4'hf: region = region_rom;   // Char and kernal ROMs
            4'h9:                         region = region_io_other;
            default:                      region = region_ram;
         endcase
      end
   end

   assign seen = i_wb_cyc & i_wb_stb & ~o_wb_ack;   // Second cycle of a held stb is idle

   // Strobes land on the edge that raises ack
   assign o_reg_we  = seen & i_wb_we & (region == region_chip);
   assign o_ram_we  = seen & i_wb_we & (region == region_ram);   // ROM writes dropped
   assign o_reg_idx = chip_reg_e'(i_wb_adr[3:0]);
   assign o_reg_dat = i_wb_dat;
   assign o_ram_adr = i_wb_adr;   // RAM read data lines up with ack
   assign o_ram_dat = i_wb_dat;

   // ==============================
   // Ack and read data
   // ==============================

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_wb_ack <= 1'b0;
         region_q <= region_io_other;
      end else begin
         o_wb_ack <= seen;            // Single-cycle pulse
         if (seen)
            region_q <= region;
      end
   end

   always_ff @(posedge clk25) begin
      if (seen)
         reg_hold <= i_reg_q;
   end

   always_comb begin
      case (region_q)
         region_chip:     o_wb_dat = reg_hold;
         region_io_other: o_wb_dat = '0;
         default:         o_wb_dat = i_ram_q;   // RAM and ROM both from sys_ram
      endcase
   end

endmodule

`default_nettype wire
